/* source/jvs_pkg.sv */
// JVS link package with the protocol byte codes and the shared byte types
`default_nettype none

package jvs_pkg;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // One protocol byte as it sits on the bus or in a buffer
    typedef logic [7:0] byte_t;

    // Frame length field, also used for payload indexes
    typedef logic [7:0] length_t;

    ////////////////////////////////////////
    // Byte codes
    ////////////////////////////////////////

    // Start of every frame, never sent unescaped after it
    localparam byte_t jvs_sync = 8'hE0;

    localparam byte_t jvs_escape = 8'hD0;      // Escape prefix

    // Second byte of an escape pair
    localparam byte_t jvs_esc_sync = 8'hDF;    // D0 DF stands for E0
    localparam byte_t jvs_esc_esc  = 8'hCF;    // D0 CF stands for D0

endpackage

`default_nettype wire

/* source/uart_serializer.sv */
// UART transmitter sending one byte as 8N1 at a fixed number of clocks per bit
`default_nettype none

module uart_serializer #(
    parameter int clks_per_bit = 416
) (
    input  wire logic           clk_sys,
    input  wire logic           reset,
    input  wire logic           i_tx_start,
    input  wire jvs_pkg::byte_t i_tx_byte,
    output logic                o_tx_serial,
    output logic                o_tx_done
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    logic             busy;
    logic [cnt_w-1:0] clk_cnt;     // Cycles within the current bit
    logic [3:0]       bit_idx;     // 0 start, 1 to 8 data, 9 stop
    logic [9:0]       shift_reg;   // Stop, data and start bits, LSB goes out first

    assign o_tx_serial = busy ? shift_reg[0] : 1'b1;    // Line idles high

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            shift_reg <= '1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (!busy) begin
                if (i_tx_start) begin
                    shift_reg <= {1'b1, i_tx_byte, 1'b0};
                    clk_cnt   <= '0;
                    bit_idx   <= '0;
                    busy      <= 1'b1;
                end
            end else if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                clk_cnt   <= '0;
                shift_reg <= {1'b1, shift_reg[9:1]};
                bit_idx   <= bit_idx + 4'd1;
                // End of the stop bit
                if (bit_idx == 4'd9) begin
                    busy      <= 1'b0;
                    o_tx_done <= 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_deserializer.sv */
// UART receiver sampling 8N1 serial data at mid bit and flagging each good byte
`default_nettype none

module uart_deserializer #(
    parameter int clks_per_bit = 416
) (
    input  wire logic      clk_sys,
    input  wire logic      reset,
    input  wire logic      i_rx_serial,
    output logic           o_rx_valid,
    output jvs_pkg::byte_t o_rx_byte
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t           state;
    logic             rx_meta;
    logic             rx_sync;       // Synchronized line level
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            state      <= st_idle;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_meta    <= i_rx_serial;
            rx_sync    <= rx_meta;
            o_rx_valid <= 1'b0;
            clk_cnt    <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= st_start;    // Falling edge of start bit
                end
                st_start: if (clk_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync ? st_idle : st_data;    // Glitch check
                end
                st_data: if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                    clk_cnt   <= '0;
                    o_rx_byte <= {rx_sync, o_rx_byte[7:1]};    // LSB first
                    bit_idx   <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= st_stop;
                end
                st_stop: if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                    o_rx_valid <= rx_sync;    // Framing error drops the byte
                    state      <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/jvs_frame_encoder.sv */
// JVS frame encoder with push buffer, RS485 direction timing and byte escaping
`default_nettype none

module jvs_frame_encoder #(
    parameter int buffer_depth = 256,
    parameter int setup_cycles = 480,
    parameter int hold_cycles  = 1440
) (
    input  wire logic           clk_sys,
    input  wire logic           reset,
    input  wire jvs_pkg::byte_t i_tx_data,
    input  wire logic           i_tx_push,
    input  wire jvs_pkg::byte_t i_dst_node,
    input  wire logic           i_commit,
    output logic                o_tx_ready,
    output logic                o_rts_n,
    output logic                o_byte_start,
    output jvs_pkg::byte_t      o_byte,
    input  wire logic           i_byte_done
);

    localparam int addr_w  = $clog2(buffer_depth);
    localparam int max_len = (buffer_depth > 255) ? 255 : buffer_depth;
    localparam int timer_w =
        $clog2(((setup_cycles > hold_cycles) ? setup_cycles : hold_cycles) + 1);

    typedef enum logic [2:0] {
        st_idle, st_setup, st_sync, st_node, st_length, st_data, st_checksum, st_hold
    } state_t;

    state_t           state;
    jvs_pkg::byte_t   buffer [buffer_depth];
    jvs_pkg::length_t push_count;
    jvs_pkg::length_t data_idx;
    jvs_pkg::byte_t   node_q;
    jvs_pkg::byte_t   checksum;
    logic [timer_w-1:0] timer;      // Shared by setup and hold
    logic             byte_busy;    // Serializer still sending
    logic             esc_pending;  // Prefix sent, code byte next
    logic             push_ok;
    logic             needs_esc;
    jvs_pkg::byte_t   field;        // Unescaped byte of the current field
    jvs_pkg::byte_t   esc_code;

    assign push_ok = i_tx_push && o_tx_ready && (push_count < jvs_pkg::length_t'(max_len));

    always_comb begin
        case (state)
            st_node:   field = node_q;
            st_length: field = push_count;
            st_data:   field = buffer[data_idx[addr_w-1:0]];
            default:   field = checksum;
        endcase
    end

    assign needs_esc = (field == jvs_pkg::jvs_sync) || (field == jvs_pkg::jvs_escape);
    assign esc_code  = (field == jvs_pkg::jvs_sync) ? jvs_pkg::jvs_esc_sync
                                                    : jvs_pkg::jvs_esc_esc;

    always_ff @(posedge clk_sys) begin
        if (push_ok) buffer[push_count[addr_w-1:0]] <= i_tx_data;
    end

    ////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state        <= st_idle;
            push_count   <= '0;
            data_idx     <= '0;
            checksum     <= '0;
            timer        <= '0;
            byte_busy    <= 1'b0;
            esc_pending  <= 1'b0;
            o_tx_ready   <= 1'b1;
            o_rts_n      <= 1'b1;
            o_byte_start <= 1'b0;
        end else begin
            o_byte_start <= 1'b0;
            if (i_byte_done) byte_busy <= 1'b0;
            if (push_ok) push_count <= push_count + 8'd1;
            case (state)
                st_idle: if (i_commit && o_tx_ready) begin
                    node_q     <= i_dst_node;
                    o_tx_ready <= 1'b0;
                    timer      <= '0;
                    state      <= st_setup;
                end
                st_setup: begin
                    timer <= timer + 1'b1;
                    if (timer == timer_w'(setup_cycles - 1)) begin
                        o_rts_n <= 1'b0;    // Take the bus
                        state   <= st_sync;
                    end
                end
                st_sync: if (!byte_busy) begin
                    o_byte       <= jvs_pkg::jvs_sync;    // Never escaped
                    o_byte_start <= 1'b1;
                    byte_busy    <= 1'b1;
                    checksum     <= '0;
                    data_idx     <= '0;
                    state        <= st_node;
                end
                st_node, st_length, st_data, st_checksum: if (!byte_busy) begin
                    o_byte_start <= 1'b1;
                    byte_busy    <= 1'b1;
                    esc_pending  <= !esc_pending && needs_esc;
                    if (esc_pending) o_byte <= esc_code;
                    else if (needs_esc) o_byte <= jvs_pkg::jvs_escape;
                    else o_byte <= field;
                    // Field done once its last byte is on its way
                    if (esc_pending || !needs_esc) begin
                        checksum <= checksum + field;
                        case (state)
                            st_node:   state <= st_length;
                            st_length: state <= (push_count == '0) ? st_checksum : st_data;
                            st_data: begin
                                data_idx <= data_idx + 8'd1;
                                if (data_idx == push_count - 8'd1) state <= st_checksum;
                            end
                            default: begin
                                timer <= '0;
                                state <= st_hold;
                            end
                        endcase
                    end
                end
                st_hold: if (!byte_busy) begin
                    timer <= timer + 1'b1;
                    if (timer == timer_w'(hold_cycles - 1)) begin
                        o_rts_n    <= 1'b1;
                        o_tx_ready <= 1'b1;
                        push_count <= '0;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/jvs_frame_decoder.sv */
// JVS frame decoder removing escapes, checking the sum and serving payload readback
`default_nettype none

module jvs_frame_decoder #(
    parameter int buffer_depth = 256
) (
    input  wire logic           clk_sys,
    input  wire logic           reset,
    input  wire logic           i_byte_valid,
    input  wire jvs_pkg::byte_t i_byte,
    output jvs_pkg::byte_t      o_src_node,
    output jvs_pkg::byte_t      o_rx_byte,
    input  wire logic           i_rx_next,
    output jvs_pkg::length_t    o_rx_remaining,
    output logic                o_rx_complete,
    output logic                o_rx_error
);

    localparam int addr_w  = $clog2(buffer_depth);
    localparam int max_len = (buffer_depth > 255) ? 255 : buffer_depth;

    typedef enum logic [2:0] {st_idle, st_node, st_length, st_data, st_validate} state_t;

    state_t           state;
    jvs_pkg::byte_t   buffer [buffer_depth];
    logic             esc_mode;
    logic             dec_valid;    // Unescaped byte available this cycle
    jvs_pkg::byte_t   dec_byte;
    jvs_pkg::byte_t   node_q;
    jvs_pkg::length_t len_q;
    jvs_pkg::length_t wr_idx;
    jvs_pkg::length_t rd_idx;
    jvs_pkg::byte_t   sum;

    // Escape removal, a raw sync always restarts the frame
    always_comb begin
        dec_valid = 1'b0;
        dec_byte  = i_byte;
        if (i_byte_valid && (i_byte != jvs_pkg::jvs_sync) && (state != st_idle)) begin
            if (esc_mode) begin
                dec_valid = (i_byte == jvs_pkg::jvs_esc_sync) ||
                            (i_byte == jvs_pkg::jvs_esc_esc);    // Bad pair is dropped
                dec_byte  = (i_byte == jvs_pkg::jvs_esc_sync) ? jvs_pkg::jvs_sync
                                                              : jvs_pkg::jvs_escape;
            end else begin
                dec_valid = (i_byte != jvs_pkg::jvs_escape);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == st_data && dec_valid && wr_idx < jvs_pkg::length_t'(max_len))
            buffer[wr_idx[addr_w-1:0]] <= dec_byte;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state          <= st_idle;
            esc_mode       <= 1'b0;
            wr_idx         <= '0;
            rd_idx         <= '0;
            sum            <= '0;
            o_rx_remaining <= '0;
            o_rx_complete  <= 1'b0;
            o_rx_error     <= 1'b0;
        end else begin
            o_rx_complete <= 1'b0;
            o_rx_error    <= 1'b0;
            if (i_byte_valid) esc_mode <= !esc_mode && (i_byte == jvs_pkg::jvs_escape);

            // Sequential readback
            if (i_rx_next && o_rx_remaining != '0) begin
                rd_idx         <= rd_idx + 8'd1;
                o_rx_byte      <= buffer[addr_w'(rd_idx + 8'd1)];
                o_rx_remaining <= o_rx_remaining - 8'd1;
            end

            if (i_byte_valid && i_byte == jvs_pkg::jvs_sync) begin
                sum   <= '0;
                state <= st_node;
            end else if (dec_valid) begin
                case (state)
                    st_node: begin
                        node_q <= dec_byte;
                        sum    <= dec_byte;
                        state  <= st_length;
                    end
                    st_length: begin
                        len_q  <= dec_byte;
                        sum    <= sum + dec_byte;
                        wr_idx <= '0;
                        state  <= (dec_byte == '0) ? st_validate : st_data;
                    end
                    st_data: begin
                        sum    <= sum + dec_byte;
                        wr_idx <= wr_idx + 8'd1;
                        if (wr_idx == len_q - 8'd1) state <= st_validate;
                    end
                    st_validate: begin
                        // Received byte is the checksum
                        if (dec_byte == sum) begin
                            o_src_node     <= node_q;
                            o_rx_byte      <= buffer[0];
                            rd_idx         <= '0;
                            o_rx_remaining <= (len_q == '0) ? '0 : len_q - 8'd1;
                            o_rx_complete  <= 1'b1;
                        end else begin
                            o_rx_error <= 1'b1;
                        end
                        state <= st_idle;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/jvs_link.sv */
// JVS link top level joining the frame encoder and decoder to the UART line
`default_nettype none

module jvs_link #(
    parameter int clks_per_bit = 416,
    parameter int setup_cycles = 480,
    parameter int hold_cycles  = 1440,
    parameter int buffer_depth = 256
) (
    input  wire logic           clk_sys,
    input  wire logic           reset,
    // Line side
    input  wire logic           i_uart_rx,
    output logic                o_uart_tx,
    output logic                o_rts_n,
    // Host transmit
    input  wire jvs_pkg::byte_t i_tx_data,
    input  wire logic           i_tx_push,
    input  wire jvs_pkg::byte_t i_dst_node,
    input  wire logic           i_commit,
    output logic                o_tx_ready,
    // Host receive
    output jvs_pkg::byte_t      o_src_node,
    output jvs_pkg::byte_t      o_rx_byte,
    input  wire logic           i_rx_next,
    output jvs_pkg::length_t    o_rx_remaining,
    output logic                o_rx_complete,
    output logic                o_rx_error
);

    logic           tx_start;
    jvs_pkg::byte_t tx_byte;
    logic           tx_done;
    logic           rx_valid;
    jvs_pkg::byte_t rx_byte;

    ////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////
    jvs_frame_encoder #(
        .buffer_depth(buffer_depth),
        .setup_cycles(setup_cycles),
        .hold_cycles (hold_cycles)
    ) i_jvs_frame_encoder (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .i_tx_data   (i_tx_data),
        .i_tx_push   (i_tx_push),
        .i_dst_node  (i_dst_node),
        .i_commit    (i_commit),
        .o_tx_ready  (o_tx_ready),
        .o_rts_n     (o_rts_n),
        .o_byte_start(tx_start),
        .o_byte      (tx_byte),
        .i_byte_done (tx_done)
    );

    uart_serializer #(.clks_per_bit(clks_per_bit)) i_uart_serializer (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .i_tx_start (tx_start),
        .i_tx_byte  (tx_byte),
        .o_tx_serial(o_uart_tx),
        .o_tx_done  (tx_done)
    );

    ////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////
    uart_deserializer #(.clks_per_bit(clks_per_bit)) i_uart_deserializer (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .i_rx_serial(i_uart_rx),
        .o_rx_valid (rx_valid),
        .o_rx_byte  (rx_byte)
    );

    jvs_frame_decoder #(.buffer_depth(buffer_depth)) i_jvs_frame_decoder (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .i_byte_valid  (rx_valid),
        .i_byte        (rx_byte),
        .o_src_node    (o_src_node),
        .o_rx_byte     (o_rx_byte),
        .i_rx_next     (i_rx_next),
        .o_rx_remaining(o_rx_remaining),
        .o_rx_complete (o_rx_complete),
        .o_rx_error    (o_rx_error)
    );

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
// Clock and reset source for the JVS link testbench
`default_nettype none

module clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 3
) (
    output logic clk_sys,
    output logic reset
);

    initial begin
        clk_sys = 1'b0;
        forever #(period / 2) clk_sys = ~clk_sys;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk_sys);
        #2 reset = 1'b0;    // Released off the edge like all other inputs
    end

endmodule

`default_nettype wire

/* verification/jvs_link_tb.sv */
// Testbench for the JVS link with a serial line monitor, a serial driver and frame checks
`default_nettype none

module jvs_link_tb;

    localparam int clks_per_bit = 8;
    localparam int setup_cycles = 20;
    localparam int hold_cycles  = 40;
    localparam int buffer_depth = 32;
    localparam int clk_period   = 20;
    localparam int bit_time     = clks_per_bit * clk_period;

    ////////////////////////////////////////
    // Run length budget
    ////////////////////////////////////////
    localparam int tx_len [4]     = '{3, 8, 17, 32};
    localparam int frame_count    = 9;     // 5 sent, 4 received
    localparam int payload_total  = 85;
    localparam int max_bytes      = 2 * (payload_total + 3 * frame_count) + frame_count;
    localparam int timeout_cycles =
        2 * (max_bytes * 10 * clks_per_bit + frame_count * (setup_cycles + hold_cycles));

    typedef logic [7:0] byte_q_t [$];

    logic             clk_sys;
    logic             reset;
    logic             i_uart_rx;
    logic             o_uart_tx;
    logic             o_rts_n;
    jvs_pkg::byte_t   i_tx_data;
    logic             i_tx_push;
    jvs_pkg::byte_t   i_dst_node;
    logic             i_commit;
    logic             o_tx_ready;
    jvs_pkg::byte_t   o_src_node;
    jvs_pkg::byte_t   o_rx_byte;
    logic             i_rx_next;
    jvs_pkg::length_t o_rx_remaining;
    logic             o_rx_complete;
    logic             o_rx_error;

    integer  seed;
    int      checks;
    int      errors;
    int      cycle_count;
    int      complete_count;
    int      error_count;
    byte_q_t line_bytes;      // Bytes seen on o_uart_tx
    time     stop_end;        // End of the last stop bit on o_uart_tx

    clock_gen #(.period(clk_period), .reset_cycles(3)) i_clock_gen (
        .clk_sys(clk_sys),
        .reset  (reset)
    );

    jvs_link #(
        .clks_per_bit(clks_per_bit),
        .setup_cycles(setup_cycles),
        .hold_cycles (hold_cycles),
        .buffer_depth(buffer_depth)
    ) i_jvs_link (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .i_uart_rx     (i_uart_rx),
        .o_uart_tx     (o_uart_tx),
        .o_rts_n       (o_rts_n),
        .i_tx_data     (i_tx_data),
        .i_tx_push     (i_tx_push),
        .i_dst_node    (i_dst_node),
        .i_commit      (i_commit),
        .o_tx_ready    (o_tx_ready),
        .o_src_node    (o_src_node),
        .o_rx_byte     (o_rx_byte),
        .i_rx_next     (i_rx_next),
        .o_rx_remaining(o_rx_remaining),
        .o_rx_complete (o_rx_complete),
        .o_rx_error    (o_rx_error)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Sync followed by the escaped node, length, data and 8-bit sum
    function automatic void encode_frame(input logic [7:0] node, input byte_q_t data,
                                         output byte_q_t frame);
        byte_q_t    fields;
        logic [7:0] sum;
        fields.delete();
        fields.push_back(node);
        fields.push_back(8'(data.size()));
        foreach (data[i]) fields.push_back(data[i]);
        sum = 8'h00;
        foreach (fields[i]) sum = sum + fields[i];
        fields.push_back(sum);
        frame.delete();
        frame.push_back(8'hE0);
        foreach (fields[i]) begin
            if (fields[i] == 8'hE0) begin
                frame.push_back(8'hD0);
                frame.push_back(8'hDF);
            end else if (fields[i] == 8'hD0) begin
                frame.push_back(8'hD0);
                frame.push_back(8'hCF);
            end else begin
                frame.push_back(fields[i]);
            end
        end
    endfunction

    // Unpacks a constant with the first byte in the top bits
    function automatic void bytes_from(input logic [63:0] word, input int count,
                                       output byte_q_t q);
        q.delete();
        for (int i = 0; i < count; i++) q.push_back(word[8 * (count - 1 - i) +: 8]);
    endfunction

    task automatic random_payload(input int len, output byte_q_t q);
        q.delete();
        repeat (len) q.push_back(8'($random(seed)));
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic report_counts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

    ////////////////////////////////////////
    // Line monitor and line driver
    ////////////////////////////////////////
    initial begin : line_monitor
        logic [7:0] rx_b;
        time        t_start;
        @(negedge reset);
        forever begin
            @(negedge o_uart_tx);
            t_start = $time;
            check_value("rts_n at start bit", 0, o_rts_n);
            #(bit_time + bit_time / 2 + clk_period / 2);    // Middle of bit 0 between edges
            for (int i = 0; i < 8; i++) begin
                rx_b[i] = o_uart_tx;
                #(bit_time);
            end
            check_value("stop bit", 1, o_uart_tx);
            line_bytes.push_back(rx_b);
            stop_end = t_start + 10 * bit_time;
        end
    end

    task automatic drive_serial_frame(input byte_q_t raw);
        logic [9:0] bits;
        @(posedge clk_sys);
        #2;
        foreach (raw[n]) begin
            bits = {1'b1, raw[n], 1'b0};
            for (int i = 0; i < 10; i++) begin
                i_uart_rx = bits[i];
                repeat (clks_per_bit) @(posedge clk_sys);
                #2;
            end
        end
        repeat (2 * clks_per_bit) @(posedge clk_sys);    // Idle gap
    endtask

    always @(posedge clk_sys) begin
        if (o_rx_complete) complete_count <= complete_count + 1;
        if (o_rx_error) error_count <= error_count + 1;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
            report_counts();
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Transmit side
    ////////////////////////////////////////
    task automatic transmit_and_compare(input string name, input logic [7:0] node,
                                        input byte_q_t data, input bit push_while_busy);
        byte_q_t expect_q;
        bit      rts_lost;
        time     elapsed;
        encode_frame(node, data, expect_q);
        line_bytes.delete();
        rts_lost = 1'b0;
        foreach (data[i]) begin
            @(posedge clk_sys);
            #2;
            i_tx_data = data[i];
            i_tx_push = 1'b1;
        end
        @(posedge clk_sys);
        #2;
        i_tx_push  = 1'b0;
        i_dst_node = node;
        i_commit   = 1'b1;
        @(posedge clk_sys);
        #2;
        i_commit = 1'b0;
        check_value({name, " ready after commit"}, 0, o_tx_ready);
        if (push_while_busy) begin
            i_tx_data = 8'hA5;    // Would lengthen the frame if taken
            i_tx_push = 1'b1;
            @(posedge clk_sys);
            #2;
            i_tx_push = 1'b0;
        end
        do begin
            @(posedge clk_sys);
            #1;
            if (!o_tx_ready && line_bytes.size() > 0 && o_rts_n) rts_lost = 1'b1;
        end while (!o_tx_ready);
        elapsed = $time - stop_end;
        check_value({name, " rts_n released"}, 1, o_rts_n);
        checks = checks + 2;
        assert (!rts_lost) else begin
            $display("%s: o_rts_n went high while the frame was still on the line", name);
            errors = errors + 1;
        end
        assert (elapsed >= hold_cycles * clk_period &&
                elapsed <= (hold_cycles + 4) * clk_period) else begin
            $display("%s: line released %0t after the last stop bit", name, elapsed);
            errors = errors + 1;
        end
        check_value({name, " byte count"}, expect_q.size(), line_bytes.size());
        foreach (expect_q[i]) begin
            if (i < line_bytes.size())
                check_value($sformatf("%s byte %0d", name, i), expect_q[i], line_bytes[i]);
        end
    endtask

    ////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////
    task automatic receive_status(input string name, input byte_q_t raw, input bit good);
        int c0;
        int e0;
        c0 = complete_count;
        e0 = error_count;
        drive_serial_frame(raw);
        do begin
            @(posedge clk_sys);
            #1;
        end while (complete_count == c0 && error_count == e0);
        check_value({name, " complete pulses"}, c0 + (good ? 1 : 0), complete_count);
        check_value({name, " error pulses"}, e0 + (good ? 0 : 1), error_count);
    endtask

    task automatic receive_and_read(input string name, input logic [7:0] node,
                                    input byte_q_t data);
        byte_q_t frame;
        encode_frame(node, data, frame);
        receive_status(name, frame, 1'b1);
        check_value({name, " source node"}, node, o_src_node);
        for (int i = 0; i < data.size(); i++) begin
            if (i > 0) begin
                @(posedge clk_sys);
                #2;
                i_rx_next = 1'b1;
                @(posedge clk_sys);
                #2;
                i_rx_next = 1'b0;
            end
            check_value($sformatf("%s payload %0d", name, i), data[i], o_rx_byte);
            check_value($sformatf("%s remaining %0d", name, i),
                        data.size() - 1 - i, o_rx_remaining);
        end
    endtask

    initial begin : stimulus
        byte_q_t    data;
        byte_q_t    raw;
        logic [7:0] node;
        seed       = 32'h2a7c_d5bd;
        checks     = 0;
        errors     = 0;
        i_uart_rx  = 1'b1;
        i_tx_data  = 8'h00;
        i_tx_push  = 1'b0;
        i_dst_node = 8'h00;
        i_commit   = 1'b0;
        i_rx_next  = 1'b0;
        @(negedge reset);
        #1;    // Reset values before the first edge out of reset
        check_value("ready after reset", 1, o_tx_ready);
        check_value("rts_n after reset", 1, o_rts_n);
        check_value("uart_tx after reset", 1, o_uart_tx);
        check_value("rx_complete after reset", 0, o_rx_complete);
        check_value("rx_error after reset", 0, o_rx_error);

        for (int f = 0; f < 4; f++) begin
            random_payload(tx_len[f], data);
            node = 8'($random(seed));
            transmit_and_compare($sformatf("random frame %0d", f), node, data, f == 0);
        end

        // Sum of E0, 05 and this payload is E0 so the checksum is escaped too
        bytes_from(64'hE0D0DFCF9D, 5, data);
        transmit_and_compare("escape frame", 8'hE0, data, 1'b0);
        receive_and_read("escape receive", 8'hE0, data);

        // Checksum 64 sent as 65
        bytes_from(64'h102030, 3, data);
        encode_frame(8'h01, data, raw);
        raw[raw.size() - 1] = raw[raw.size() - 1] + 8'h01;
        receive_status("bad checksum", raw, 1'b0);

        // Sender counts 55 but the receiver drops it after the bad D0 pair
        bytes_from(64'hE0020311D0552233, 8, raw);
        raw.push_back(8'h02 + 8'h03 + 8'h11 + 8'h55 + 8'h22 + 8'h33);
        receive_status("bad escape", raw, 1'b0);

        random_payload(8, data);
        node = 8'($random(seed));
        receive_and_read("receive after errors", node, data);

        report_counts();
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* jvs_link.f */
source/jvs_pkg.sv
source/uart_serializer.sv
source/uart_deserializer.sv
source/jvs_frame_encoder.sv
source/jvs_frame_decoder.sv
source/jvs_link.sv
verification/clock_gen.sv
verification/jvs_link_tb.sv

/* build.sh */
#!/bin/sh
# Compile the JVS link testbench with Verilator, run it and look for the pass line
verilator --binary --assert -Wno-fatal -j 0 --top-module jvs_link_tb \
    -f jvs_link.f -o sim_jvs_link \
    && ./obj_dir/sim_jvs_link | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
